// ==== hdl/ppu_decode_pkg.sv ====
package ppu_decode_pkg;

        localparam int CW_WIDTH = 19;

        typedef logic [31:0]          instruction_t;
        typedef logic [5:0]           opcode_t;    // instruction[31:26]
        typedef logic [5:0]           funct_t;     // instruction[5:0] of r-type
        typedef logic [2:0]           src_operand_t;
        typedef logic [3:0]           alu_op_t;
        typedef logic [1:0]           mem_size_t;
        typedef logic [CW_WIDTH-1:0]  control_word_t;

        // positions in the control word that the stage checks
        localparam int CW_LOAD       = 8;
        localparam int CW_MEM_RW     = 2;
        localparam int CW_MEM_ENABLE = 0;

        // second alu operand select
        localparam src_operand_t SRC_REG       = 3'b000;
        localparam src_operand_t SRC_LINK_PC   = 3'b011;  // return address for jal
        localparam src_operand_t SRC_IMM       = 3'b100;
        localparam src_operand_t SRC_UPPER_IMM = 3'b101;  // lui, imm << 16

        localparam alu_op_t ALU_ADD    = 4'b0000;
        localparam alu_op_t ALU_SUB    = 4'b0001;
        localparam alu_op_t ALU_AND    = 4'b0010;
        localparam alu_op_t ALU_OR     = 4'b0011;
        localparam alu_op_t ALU_XOR    = 4'b0100;
        localparam alu_op_t ALU_NOR    = 4'b0101;
        localparam alu_op_t ALU_SLT    = 4'b1001;
        localparam alu_op_t ALU_GTZ    = 4'b1010;
        localparam alu_op_t ALU_PASS_B = 4'b1011;
        localparam alu_op_t ALU_LINK   = 4'b1100;

        localparam mem_size_t MEM_BYTE = 2'b00;
        localparam mem_size_t MEM_HALF = 2'b01;
        localparam mem_size_t MEM_WORD = 2'b10;

        localparam opcode_t OP_RTYPE  = 6'b000000;
        localparam opcode_t OP_REGIMM = 6'b000001;  // bgez, rt ignored
        localparam opcode_t OP_J      = 6'b000010;
        localparam opcode_t OP_JAL    = 6'b000011;
        localparam opcode_t OP_BEQ    = 6'b000100;
        localparam opcode_t OP_BGTZ   = 6'b000111;

        localparam opcode_t OP_ADDI   = 6'b001000;
        localparam opcode_t OP_ADDIU  = 6'b001001;
        localparam opcode_t OP_SLTI   = 6'b001010;
        localparam opcode_t OP_SLTIU  = 6'b001011;
        localparam opcode_t OP_ANDI   = 6'b001100;
        localparam opcode_t OP_ORI    = 6'b001101;
        localparam opcode_t OP_XORI   = 6'b001110;
        localparam opcode_t OP_LUI    = 6'b001111;

        localparam opcode_t OP_LB     = 6'b100000;
        localparam opcode_t OP_LH     = 6'b100001;
        localparam opcode_t OP_LW     = 6'b100011;
        localparam opcode_t OP_LBU    = 6'b100100;
        localparam opcode_t OP_LHU    = 6'b100101;
        localparam opcode_t OP_SB     = 6'b101000;
        localparam opcode_t OP_SH     = 6'b101001;
        localparam opcode_t OP_SW     = 6'b101011;

        localparam funct_t FN_ADD     = 6'b100000;
        localparam funct_t FN_ADDU    = 6'b100001;
        localparam funct_t FN_SUB     = 6'b100010;
        localparam funct_t FN_SUBU    = 6'b100011;
        localparam funct_t FN_AND     = 6'b100100;
        localparam funct_t FN_OR      = 6'b100101;
        localparam funct_t FN_XOR     = 6'b100110;
        localparam funct_t FN_NOR     = 6'b100111;
        localparam funct_t FN_SLT     = 6'b101010;
        localparam funct_t FN_SLTU    = 6'b101011;
        localparam funct_t FN_JR      = 6'b001000;

endpackage

// ==== hdl/execute_fields_if.sv ====
`timescale 1ns/1ps

interface execute_fields_if;
        import ppu_decode_pkg::*;

        src_operand_t src_operand;
        alu_op_t      alu_op;
        logic         rf_enable;
        logic         rt_dest;     // write rt instead of rd
        logic         link_r31;    // jal writes r31
        logic         recognized;  // opcode/funct is in the kept set

        modport source (
                output src_operand, alu_op, rf_enable, rt_dest, link_r31, recognized
        );

        modport sink (
                input src_operand, alu_op, rf_enable, rt_dest, link_r31, recognized
        );

endinterface

// ==== hdl/access_fields_if.sv ====
`timescale 1ns/1ps

interface access_fields_if;
        import ppu_decode_pkg::*;

        logic      load;
        mem_size_t mem_size;
        logic      mem_rw;         // 1 = store
        logic      mem_se;         // sign extend load data
        logic      mem_enable;
        logic      branch;         // conditional branch
        logic      target_addr;    // next pc from a computed target
        logic      unconditional;  // j, jal, jr

        modport source (
                output load, mem_size, mem_rw, mem_se, mem_enable,
                       branch, target_addr, unconditional
        );

        modport sink (
                input load, mem_size, mem_rw, mem_se, mem_enable,
                      branch, target_addr, unconditional
        );

endinterface

// ==== hdl/execute_decoder.sv ====
`timescale 1ns/1ps

module execute_decoder (
        input  ppu_decode_pkg::instruction_t instruction,
        execute_fields_if.source             fields
);
        import ppu_decode_pkg::*;

        opcode_t opcode;
        funct_t  funct;

        assign opcode = instruction[31:26];
        assign funct  = instruction[5:0];

        always_comb begin
                fields.src_operand = SRC_REG;
                fields.alu_op      = ALU_ADD;
                fields.rf_enable   = 1'b0;
                fields.rt_dest     = 1'b0;
                fields.link_r31    = 1'b0;
                fields.recognized  = 1'b0;

                case (opcode)
                        OP_RTYPE: begin
                                fields.recognized = 1'b1;
                                fields.rf_enable  = 1'b1;
                                case (funct)
                                        FN_ADD, FN_ADDU: fields.alu_op = ALU_ADD;
                                        FN_SUB, FN_SUBU: fields.alu_op = ALU_SUB;
                                        FN_AND:          fields.alu_op = ALU_AND;
                                        FN_OR:           fields.alu_op = ALU_OR;
                                        FN_XOR:          fields.alu_op = ALU_XOR;
                                        FN_NOR:          fields.alu_op = ALU_NOR;
                                        FN_SLT, FN_SLTU: fields.alu_op = ALU_SLT;
                                        FN_JR:           fields.rf_enable = 1'b0;  // no write back
                                        default: begin  // shifts and the rest
                                                fields.recognized = 1'b0;
                                                fields.rf_enable  = 1'b0;
                                        end
                                endcase
                        end

                        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                        OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                                fields.recognized  = 1'b1;
                                fields.rf_enable   = 1'b1;
                                fields.rt_dest     = 1'b1;
                                fields.src_operand = SRC_IMM;
                                case (opcode)
                                        OP_SLTI, OP_SLTIU: fields.alu_op = ALU_SLT;
                                        OP_ANDI:           fields.alu_op = ALU_AND;
                                        OP_ORI:            fields.alu_op = ALU_OR;
                                        OP_XORI:           fields.alu_op = ALU_XOR;
                                        OP_LUI: begin
                                                fields.src_operand = SRC_UPPER_IMM;
                                                fields.alu_op      = ALU_PASS_B;
                                        end
                                        default:           fields.alu_op = ALU_ADD;  // addi, addiu
                                endcase
                        end

                        // address is rs + offset for every memory access
                        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                                fields.recognized  = 1'b1;
                                fields.rf_enable   = 1'b1;
                                fields.rt_dest     = 1'b1;
                                fields.src_operand = SRC_IMM;
                        end

                        OP_SB, OP_SH, OP_SW: begin
                                fields.recognized  = 1'b1;
                                fields.src_operand = SRC_IMM;
                        end

                        OP_BEQ: begin
                                fields.recognized = 1'b1;
                                fields.alu_op     = ALU_SUB;  // zero flag gives equality
                        end

                        OP_BGTZ, OP_REGIMM: begin
                                fields.recognized = 1'b1;
                                fields.alu_op     = ALU_GTZ;
                        end

                        OP_J: fields.recognized = 1'b1;

                        OP_JAL: begin
                                fields.recognized  = 1'b1;
                                fields.rf_enable   = 1'b1;
                                fields.link_r31    = 1'b1;
                                fields.src_operand = SRC_LINK_PC;
                                fields.alu_op      = ALU_LINK;
                        end

                        default: ;
                endcase
        end

        // a recognised instruction must never hand an undefined operation to the alu
        always_comb begin
                assert final (!(fields.recognized && $isunknown(fields.alu_op)))
                        else $error("alu_op unknown for recognised instruction %h", instruction);
        end

endmodule

// ==== hdl/access_decoder.sv ====
`timescale 1ns/1ps

module access_decoder (
        input  ppu_decode_pkg::instruction_t instruction,
        access_fields_if.source              fields
);
        import ppu_decode_pkg::*;

        opcode_t opcode;
        funct_t  funct;

        assign opcode = instruction[31:26];
        assign funct  = instruction[5:0];

        always_comb begin
                fields.load          = 1'b0;
                fields.mem_size      = MEM_BYTE;
                fields.mem_rw        = 1'b0;
                fields.mem_se        = 1'b0;
                fields.mem_enable    = 1'b0;
                fields.branch        = 1'b0;
                fields.target_addr   = 1'b0;
                fields.unconditional = 1'b0;

                case (opcode)
                        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                                fields.load       = 1'b1;
                                fields.mem_enable = 1'b1;
                                case (opcode)
                                        OP_LB: fields.mem_se = 1'b1;
                                        OP_LH: begin
                                                fields.mem_size = MEM_HALF;
                                                fields.mem_se   = 1'b1;
                                        end
                                        OP_LW:  fields.mem_size = MEM_WORD;
                                        OP_LHU: fields.mem_size = MEM_HALF;
                                        default: ;  // lbu, byte zero-extended
                                endcase
                        end

                        OP_SB, OP_SH, OP_SW: begin
                                fields.mem_rw     = 1'b1;
                                fields.mem_enable = 1'b1;
                                case (opcode)
                                        OP_SH:   fields.mem_size = MEM_HALF;
                                        OP_SW:   fields.mem_size = MEM_WORD;
                                        default: fields.mem_size = MEM_BYTE;
                                endcase
                        end

                        // any rt under regimm is taken as bgez
                        OP_BEQ, OP_BGTZ, OP_REGIMM: begin
                                fields.branch      = 1'b1;
                                fields.target_addr = 1'b1;
                        end

                        OP_J, OP_JAL: begin
                                fields.unconditional = 1'b1;
                                fields.target_addr   = 1'b1;
                        end

                        OP_RTYPE: begin
                                if (funct == FN_JR) begin
                                        fields.unconditional = 1'b1;  // target comes from rs
                                end
                        end

                        default: ;
                endcase
        end

        // an access is either a load or a store, never both
        always_comb begin
                assert final (!(fields.mem_rw && fields.load))
                        else $error("load and store both set for instruction %h", instruction);
        end

endmodule

// ==== hdl/control_word_stage.sv ====
`timescale 1ns/1ps

module control_word_stage (
        input  logic                          clk,
        input  logic                          reset,
        execute_fields_if.sink                exec_fields,
        access_fields_if.sink                 access_fields,
        output ppu_decode_pkg::control_word_t control_signals
);
        import ppu_decode_pkg::*;

        control_word_t next_word;

        always_comb begin
                next_word = {access_fields.unconditional,
                             exec_fields.link_r31,
                             exec_fields.rt_dest,
                             exec_fields.src_operand,
                             exec_fields.alu_op,
                             access_fields.load,
                             exec_fields.rf_enable,
                             access_fields.branch,
                             access_fields.target_addr,
                             access_fields.mem_size,
                             access_fields.mem_rw,
                             access_fields.mem_se,
                             access_fields.mem_enable};
                if (!exec_fields.recognized) begin
                        next_word = '0;  // unknown opcode acts as a bubble
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        control_signals <= '0;
                end else begin
                        control_signals <= next_word;
                end
        end

        // the stage leaves reset holding a bubble
        assert property (@(posedge clk) reset |=> control_signals == '0)
                else $error("control word not cleared after reset");

        // a load or a store always enables the memory
        assert property (@(posedge clk)
                (control_signals[CW_MEM_RW] || control_signals[CW_LOAD])
                        |-> control_signals[CW_MEM_ENABLE])
                else $error("memory access without mem_enable");

endmodule

// ==== hdl/ppu_control_unit.sv ====
`timescale 1ns/1ps

module ppu_control_unit (
        input  logic                          clk,
        input  logic                          reset,
        input  ppu_decode_pkg::instruction_t  instruction,
        output ppu_decode_pkg::control_word_t control_signals
);

        execute_fields_if exec_fields ();    // alu and write back side
        access_fields_if  access_fields ();  // memory and pc side

        // both decoders see the same instruction in the same cycle
        execute_decoder u_execute_decoder (
                .instruction (instruction),
                .fields      (exec_fields)
        );

        access_decoder u_access_decoder (
                .instruction (instruction),
                .fields      (access_fields)
        );

        control_word_stage u_control_word_stage (
                .clk             (clk),
                .reset           (reset),
                .exec_fields     (exec_fields),
                .access_fields   (access_fields),
                .control_signals (control_signals)
        );

endmodule

// ==== verification/tb_ppu_control_unit.sv ====
`timescale 1ns/1ps

module tb_ppu_control_unit;
        import ppu_decode_pkg::*;

        localparam int RESET_TIMEOUT = 20;  // cycles

        // kept R-type functs with jr last
        localparam funct_t KEPT_FUNCTS [11] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
                FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_JR};

        // immediates 0..7, loads 8..12, stores 13..15, transfers 16..20
        localparam opcode_t KEPT_OPS [21] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
                OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH,
                OP_SW, OP_BEQ, OP_BGTZ, OP_REGIMM, OP_J, OP_JAL};

        logic          clk = 1'b0;
        logic          reset;
        instruction_t  instruction;
        control_word_t control_signals;

        integer        seed;
        logic          pending;            // a word is still due for checking
        string         pending_name;
        control_word_t pending_expected;

        ppu_control_unit dut (
                .clk             (clk),
                .reset           (reset),
                .instruction     (instruction),
                .control_signals (control_signals)
        );

        always #20 clk = ~clk;  // 40 ns period

        function automatic logic [31:0] random_word();
                random_word = $random(seed);
        endfunction

        function automatic instruction_t rtype_word(input funct_t fn, input logic [31:0] rnd);
                return {OP_RTYPE, rnd[25:6], fn};  // rs, rt, rd, shamt random
        endfunction

        function automatic instruction_t opcode_word(input opcode_t op, input logic [31:0] rnd);
                return {op, rnd[25:0]};
        endfunction

        // reference decode of one instruction
        function automatic control_word_t expected_word(input instruction_t instr);
                opcode_t      op;
                funct_t       fn;
                logic         known, imm_class, load_class, store_class;
                logic         uncond, link, rtd, ld, rfe, br, tgt, rw, se, men;
                src_operand_t src;
                alu_op_t      alu;
                mem_size_t    sz;

                op = instr[31:26];
                fn = instr[5:0];
                {known, imm_class, load_class, store_class} = '0;
                {uncond, link, rtd, ld, rfe, br, tgt, rw, se, men} = '0;
                src = SRC_REG;
                alu = ALU_ADD;
                sz  = MEM_BYTE;

                case (op)
                        OP_RTYPE: begin
                                known = 1'b1;
                                rfe   = 1'b1;
                                case (fn)
                                        FN_ADD, FN_ADDU: alu = ALU_ADD;
                                        FN_SUB, FN_SUBU: alu = ALU_SUB;
                                        FN_AND:          alu = ALU_AND;
                                        FN_OR:           alu = ALU_OR;
                                        FN_XOR:          alu = ALU_XOR;
                                        FN_NOR:          alu = ALU_NOR;
                                        FN_SLT, FN_SLTU: alu = ALU_SLT;
                                        FN_JR: begin
                                                rfe    = 1'b0;
                                                uncond = 1'b1;
                                        end
                                        default: known = 1'b0;  // shifts and others
                                endcase
                        end
                        OP_ADDI, OP_ADDIU: imm_class = 1'b1;
                        OP_SLTI, OP_SLTIU: begin
                                imm_class = 1'b1;
                                alu       = ALU_SLT;
                        end
                        OP_ANDI: begin
                                imm_class = 1'b1;
                                alu       = ALU_AND;
                        end
                        OP_ORI: begin
                                imm_class = 1'b1;
                                alu       = ALU_OR;
                        end
                        OP_XORI: begin
                                imm_class = 1'b1;
                                alu       = ALU_XOR;
                        end
                        OP_LUI: begin
                                imm_class = 1'b1;
                                alu       = ALU_PASS_B;
                        end
                        OP_LB: begin
                                load_class = 1'b1;
                                se         = 1'b1;
                        end
                        OP_LH: begin
                                load_class = 1'b1;
                                sz         = MEM_HALF;
                                se         = 1'b1;
                        end
                        OP_LW: begin
                                load_class = 1'b1;
                                sz         = MEM_WORD;
                        end
                        OP_LBU: load_class = 1'b1;
                        OP_LHU: begin
                                load_class = 1'b1;
                                sz         = MEM_HALF;
                        end
                        OP_SB: store_class = 1'b1;
                        OP_SH: begin
                                store_class = 1'b1;
                                sz          = MEM_HALF;
                        end
                        OP_SW: begin
                                store_class = 1'b1;
                                sz          = MEM_WORD;
                        end
                        OP_BEQ: begin
                                {known, br, tgt} = 3'b111;
                                alu = ALU_SUB;
                        end
                        OP_BGTZ, OP_REGIMM: begin  // regimm is bgez for any rt
                                {known, br, tgt} = 3'b111;
                                alu = ALU_GTZ;
                        end
                        OP_J: {known, uncond, tgt} = 3'b111;
                        OP_JAL: begin
                                {known, uncond, tgt, link, rfe} = 5'b11111;
                                src = SRC_LINK_PC;
                                alu = ALU_LINK;
                        end
                        default: ;
                endcase

                if (imm_class) begin
                        {known, rfe, rtd} = 3'b111;
                        src = (op == OP_LUI) ? SRC_UPPER_IMM : SRC_IMM;
                end
                if (load_class) begin
                        {known, ld, rfe, rtd, men} = 5'b11111;
                        src = SRC_IMM;
                end
                if (store_class) begin
                        {known, rw, men} = 3'b111;
                        src = SRC_IMM;
                end
                if (!known) begin
                        return '0;
                end
                return {uncond, link, rtd, src, alu, ld, rfe, br, tgt, sz, rw, se, men};
        endfunction

        task automatic stop_on_failure();
                $display("Errors found");
                $fatal(1, "simulation stopped at the first failure");
        endtask

        task automatic check_word(input string name, input control_word_t expected,
                                  input control_word_t actual);
                if (actual !== expected) begin
                        $display("[FAIL] %s expected %b actual %b", name, expected, actual);
                        stop_on_failure();
                end
        endtask

        // drive one instruction and check the word of the one before it
        task automatic issue_instruction(input string name, input instruction_t instr,
                                         input control_word_t expected);
                @(posedge clk);
                instruction <= instr;
                @(negedge clk);
                if (pending) begin
                        check_word(pending_name, pending_expected, control_signals);
                end
                pending          = 1'b1;
                pending_name     = name;
                pending_expected = expected;
        endtask

        task automatic drain_pending();
                @(posedge clk);
                @(negedge clk);
                if (pending) begin
                        check_word(pending_name, pending_expected, control_signals);
                end
                pending = 1'b0;
        endtask

        task automatic wait_reset_release();
                int cycles;

                cycles = 0;
                while (reset !== 1'b0) begin
                        @(posedge clk);
                        cycles++;
                        if (cycles > RESET_TIMEOUT) begin
                                $display("reset was still high after %0d cycles", cycles);
                                stop_on_failure();
                        end
                end
        endtask

        task automatic reset_clears_word();
                for (int i = 0; i < 3; i++) begin
                        @(posedge clk);
                        if (i == 0) begin
                                instruction <= rtype_word(FN_ADD, random_word());  // would decode
                        end
                        if (i == 2) begin
                                reset       <= 1'b0;
                                instruction <= '0;
                        end
                        @(negedge clk);
                        check_word($sformatf("reset cycle %0d", i), '0, control_signals);
                end
                wait_reset_release();
                @(posedge clk);
                @(negedge clk);
                check_word("first cycle after reset", '0, control_signals);
        endtask

        task automatic alu_operations();
                instruction_t w;

                for (int i = 0; i < 10; i++) begin
                        w = rtype_word(KEPT_FUNCTS[i], random_word());
                        issue_instruction($sformatf("rtype funct %b", KEPT_FUNCTS[i]), w,
                                          expected_word(w));
                end
                for (int i = 0; i < 8; i++) begin
                        w = opcode_word(KEPT_OPS[i], random_word());
                        issue_instruction($sformatf("immediate op %b", KEPT_OPS[i]), w,
                                          expected_word(w));
                end
                drain_pending();
        endtask

        task automatic loads_and_stores();
                instruction_t w;

                for (int i = 8; i < 16; i++) begin
                        w = opcode_word(KEPT_OPS[i], random_word());
                        issue_instruction($sformatf("memory op %b", KEPT_OPS[i]), w,
                                          expected_word(w));
                end
                drain_pending();
        endtask

        task automatic control_transfers();
                instruction_t w;

                for (int i = 16; i < 21; i++) begin
                        w = opcode_word(KEPT_OPS[i], random_word());
                        issue_instruction($sformatf("transfer op %b", KEPT_OPS[i]), w,
                                          expected_word(w));
                end
                w = rtype_word(FN_JR, random_word());
                issue_instruction("jr", w, expected_word(w));
                drain_pending();
        endtask

        task automatic unrecognised_words();
                instruction_t w;

                issue_instruction("all zero", '0, '0);
                issue_instruction("shift srl", rtype_word(6'b000010, random_word()), '0);
                issue_instruction("unused opcode", opcode_word(6'b010000, random_word()), '0);
                issue_instruction("dropped bne", opcode_word(6'b000101, random_word()), '0);
                for (int i = 0; i < 24; i++) begin
                        w = random_word();
                        if (expected_word(w) == '0) begin  // skip words that hit the kept set
                                issue_instruction($sformatf("random word %h", w), w, '0);
                        end
                end
                drain_pending();
        endtask

        task automatic back_to_back_stream();
                instruction_t w;
                logic [31:0]  rnd;
                logic [4:0]   pick;

                for (int i = 0; i < 64; i++) begin
                        rnd  = random_word();
                        pick = rnd[31:27];
                        if (pick < 5'd11) begin
                                w = rtype_word(KEPT_FUNCTS[pick[3:0]], random_word());
                        end else begin
                                w = opcode_word(KEPT_OPS[pick - 5'd11], random_word());
                        end
                        issue_instruction($sformatf("stream %0d word %h", i, w), w,
                                          expected_word(w));
                end
                drain_pending();
        endtask

        initial begin
                seed        = 32'h083e_7154;
                pending     = 1'b0;
                reset       = 1'b1;
                instruction = '0;

                reset_clears_word();
                alu_operations();
                loads_and_stores();
                control_transfers();
                unrecognised_words();
                back_to_back_stream();

                $display("No errors");
                $finish;
        end

endmodule

// ==== ppu_control_unit.f ====
hdl/ppu_decode_pkg.sv
hdl/execute_fields_if.sv
hdl/access_fields_if.sv
hdl/execute_decoder.sv
hdl/access_decoder.sv
hdl/control_word_stage.sv
hdl/ppu_control_unit.sv
verification/tb_ppu_control_unit.sv

// ==== Makefile ====
# Verilator simulation of the decode control unit

VERILATOR ?= verilator
LOG       ?= sim.log
TOP       ?= tb_ppu_control_unit
FILELIST  ?= ppu_control_unit.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= No errors

VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR LOG TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
